//--- dv/otp_input.txt
# op and fields: W addr data, R addr, L d0 d1 d2 d3, E, P count
# addr and count are decimal, data is hex
W 0 00f0
R 0
W 0 00ff
W 0 000f
R 0
W 1 1234
R 1
W 1 0004
R 1
W 11 8001
R 11
W 12 ffff
R 14
L 0001 0003 0007 000f
P 3
L 0000 0000 0000 0000
E
W 2 a5a5
R 2

//--- compile.f
src/otp_macro_pkg.sv
src/otp_ctrl_pkg.sv
src/otp_port_if.sv
src/otp_macro.sv
src/otp_port_arb.sv
src/otp_lci.sv
src/otp_dai.sv
src/otp_ctrl_top.sv
dv/tb_otp_ctrl.sv

//--- Makefile
SIM := obj_dir/Vtb_otp_ctrl

all: run

# Rebuilt only when a source or the file list changes
$(SIM): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_otp_ctrl -f compile.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- dv/tb_otp_ctrl.sv
// Self-checking OTP controller testbench with file-driven operations and a shadow OTP array
`timescale 1ns/1ps

module tb_otp_ctrl
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
();

  localparam int Timeout = 100;
  localparam int LcBase  = LcOffsetDefault;
  localparam int LcWords = LcNumWordsDefault;

  logic                    clk_i, rst_ni, lci_en_i;
  lc_tx_t                  escalate_en_i;
  logic                    lc_req_i, lc_ack_o, lc_err_o;
  otp_word_t [LcWords-1:0] lc_data_i;
  logic                    wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o, wb_err_o;
  otp_addr_t               wb_adr_i;
  otp_word_t               wb_dat_i, wb_dat_o;
  otp_err_e                error_o;
  logic                    fsm_err_o, lci_idle_o;

  // Shadow copy of the OTP array
  otp_word_t shadow [OtpNumWords];
  int        errors = 0;
  int        ops = 0;
  int        seed = 99957;

  otp_ctrl_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference rule and bus drivers
  //////////////////////////////////////////////////

  // A write is refused unless every programmed bit stays set in the new word
  function automatic logic clears_bits(otp_word_t old_w, otp_word_t new_w);
    return (old_w & new_w) != old_w;
  endfunction

  // Fresh reset with the LCI held off and then enabled
  task automatic reset_dut();
    logic idle;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = LcTxOff;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    for (int i = 0; i < OtpNumWords; i++) begin
      shadow[i] = '0;
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      if (lci_idle_o !== 1'b0) begin
        $display("Mismatch at %0t: lci_idle_o got %0b expected 0", $time, lci_idle_o);
        errors++;
      end
    end
    if (error_o !== NoError) begin
      $display("Mismatch at %0t: error_o got %0d expected %0d", $time, error_o, NoError);
      errors++;
    end
    if (fsm_err_o !== 1'b0) begin
      $display("Mismatch at %0t: fsm_err_o got %0b expected 0", $time, fsm_err_o);
      errors++;
    end
    lci_en_i = 1'b1;
    idle = 1'b0;
    for (int n = 0; n < Timeout && !idle; n++) begin
      @(negedge clk_i);
      idle = lci_idle_o;
    end
    if (!idle) begin
      $display("LCI did not become idle after lci_en_i was raised");
      errors++;
    end
  endtask

  // One Wishbone classic cycle with the response predicted from the shadow array
  task automatic dai_access(input logic we, input int addr, input otp_word_t data);
    logic      exp_err, got_ack, got_err;
    otp_word_t exp_rd, rd;
    exp_rd  = shadow[addr];
    exp_err = (addr >= LcBase && addr < LcBase + LcWords) ||
              (we && clears_bits(shadow[addr], data));
    if (we && !exp_err) begin
      shadow[addr] = shadow[addr] | data;
    end
    got_ack = 1'b0;
    got_err = 1'b0;
    rd      = '0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = otp_addr_t'(addr);
    wb_dat_i = data;
    for (int n = 0; n < Timeout && !got_ack && !got_err; n++) begin
      @(negedge clk_i);
      got_ack = wb_ack_o;
      got_err = wb_err_o;
      rd      = wb_dat_o;
    end
    // Strobe drops for at least one cycle before the next access
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!got_ack && !got_err) begin
      $display("DAI access to word %0d got no response", addr);
      errors++;
    end else begin
      if (got_ack !== !exp_err) begin
        $display("Mismatch at %0t: wb_ack_o got %0b expected %0b", $time, got_ack, !exp_err);
        errors++;
      end
      if (got_err !== exp_err) begin
        $display("Mismatch at %0t: wb_err_o got %0b expected %0b", $time, got_err, exp_err);
        errors++;
      end
      if (!we && !exp_err && rd !== exp_rd) begin
        $display("Mismatch at %0t: wb_dat_o got %h expected %h", $time, rd, exp_rd);
        errors++;
      end
    end
  endtask

  // LC transition over the whole partition that must stay unanswered without expect_ack
  task automatic lc_transition(input otp_word_t data [LcWords], input logic expect_ack);
    logic exp_err, got_ack, got_err;
    exp_err = 1'b0;
    got_ack = 1'b0;
    got_err = 1'b0;
    if (expect_ack) begin
      for (int i = 0; i < LcWords; i++) begin
        if (clears_bits(shadow[LcBase+i], data[i])) begin
          exp_err = 1'b1;
        end else begin
          shadow[LcBase+i] = shadow[LcBase+i] | data[i];
        end
      end
    end
    @(negedge clk_i);
    for (int i = 0; i < LcWords; i++) begin
      lc_data_i[i] = data[i];
    end
    lc_req_i = 1'b1;
    for (int n = 0; n < Timeout && !got_ack; n++) begin
      @(negedge clk_i);
      got_ack = lc_ack_o;
      got_err = lc_err_o;
    end
    lc_req_i = 1'b0;
    if (!expect_ack) begin
      if (got_ack) begin
        $display("LC transition was acknowledged after escalation");
        errors++;
      end
    end else if (!got_ack) begin
      $display("LC transition got no lc_ack_o");
      errors++;
    end else begin
      if (got_err !== exp_err) begin
        $display("Mismatch at %0t: lc_err_o got %0b expected %0b", $time, got_err, exp_err);
        errors++;
      end
      // A failed transition leaves the LCI locked and not idle
      @(negedge clk_i);
      if (lci_idle_o !== !exp_err) begin
        $display("Mismatch at %0t: lci_idle_o got %0b expected %0b", $time, lci_idle_o,
                 !exp_err);
        errors++;
      end
      if (exp_err && error_o !== MacroWriteBlankError) begin
        $display("Mismatch at %0t: error_o got %0d expected %0d", $time, error_o,
                 MacroWriteBlankError);
        errors++;
      end
    end
  endtask

  // DAI write to a random ordinary word while the LCI sets more bits
  task automatic parallel_round();
    int        addr;
    otp_word_t data;
    otp_word_t lw [LcWords];
    addr = int'($unsigned($random(seed)) % LcBase);
    data = otp_word_t'($random(seed));
    for (int i = 0; i < LcWords; i++) begin
      lw[i] = shadow[LcBase+i] | otp_word_t'($random(seed));
    end
    fork
      dai_access(1'b1, addr, data);
      lc_transition(lw, 1'b1);
    join
  endtask

  // One cycle of escalation locks the LCI against further transitions
  task automatic escalate_check();
    otp_word_t lw [LcWords] = '{default: '0};
    reset_dut();
    @(negedge clk_i);
    // Invalid encoding that loose decoding still treats as escalation
    escalate_en_i = 4'b0000;
    #1;
    if (fsm_err_o !== 1'b1) begin
      $display("Mismatch at %0t: fsm_err_o got %0b expected 1", $time, fsm_err_o);
      errors++;
    end
    @(negedge clk_i);
    escalate_en_i = LcTxOff;
    #1;
    if (fsm_err_o !== 1'b0) begin
      $display("Mismatch at %0t: fsm_err_o got %0b expected 0", $time, fsm_err_o);
      errors++;
    end
    if (error_o !== FsmStateError) begin
      $display("Mismatch at %0t: error_o got %0d expected %0d", $time, error_o, FsmStateError);
      errors++;
    end
    lc_transition(lw, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Operation list
  //////////////////////////////////////////////////

  initial begin : main
    int         fd, code, addr, cnt;
    logic [7:0] op;
    otp_word_t  data;
    otp_word_t  lw [LcWords];
    string      line;
    reset_dut();
    fd = $fopen("dv/otp_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the input file dv/otp_input.txt");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", op) == 1) begin
        case (op)
          "#": code = $fgets(line, fd);
          "W": begin
            code = $fscanf(fd, "%d %h", addr, data);
            dai_access(1'b1, addr, data);
          end
          "R": begin
            code = $fscanf(fd, "%d", addr);
            dai_access(1'b0, addr, '0);
          end
          "L": begin
            code = $fscanf(fd, "%h %h %h %h", lw[0], lw[1], lw[2], lw[3]);
            lc_transition(lw, 1'b1);
          end
          "E": escalate_check();
          "P": begin
            code = $fscanf(fd, "%d", cnt);
            repeat (cnt) parallel_round();
          end
          default: begin
            $display("Unknown operation %c in the input file", op);
            errors++;
          end
        endcase
        if (op != "#") begin
          ops++;
        end
      end
      $fclose(fd);
    end
    $display("Operations run: %0d, errors: %0d", ops, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_otp_ctrl

//--- src/otp_ctrl_top.sv
// OTP controller top level: LCI, DAI, port arbiter and OTP array
`timescale 1ns/1ps

module otp_ctrl_top
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
#(
  parameter int LcOffset   = LcOffsetDefault,
  parameter int LcNumWords = LcNumWordsDefault
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Life cycle side
  input  logic                       lci_en_i,
  input  lc_tx_t                     escalate_en_i,
  input  logic                       lc_req_i,
  input  otp_word_t [LcNumWords-1:0] lc_data_i,
  output logic                       lc_ack_o,
  output logic                       lc_err_o,
  // Wishbone classic side
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  otp_addr_t                  wb_adr_i,
  input  otp_word_t                  wb_dat_i,
  output otp_word_t                  wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       wb_err_o,
  // Status
  output otp_err_e                   error_o,
  output logic                       fsm_err_o,
  output logic                       lci_idle_o
);

  otp_port_if lci_port ();
  otp_port_if dai_port ();
  otp_port_if macro_port ();

  otp_lci #(
    .LcOffset   (LcOffset),
    .LcNumWords (LcNumWords)
  ) u_lci (
    .clk_i,
    .rst_ni,
    .lci_en_i,
    .escalate_en_i,
    .lc_req_i,
    .lc_data_i,
    .lc_ack_o,
    .lc_err_o,
    .error_o,
    .fsm_err_o,
    .lci_idle_o,
    .port       (lci_port)
  );

  otp_dai #(
    .LcOffset   (LcOffset),
    .LcNumWords (LcNumWords)
  ) u_dai (
    .clk_i,
    .rst_ni,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o,
    .port       (dai_port)
  );

  // LCI has priority on the shared macro port
  otp_port_arb u_arb (
    .clk_i,
    .rst_ni,
    .lci_port   (lci_port),
    .dai_port   (dai_port),
    .macro_port (macro_port)
  );

  otp_macro u_macro (
    .clk_i,
    .rst_ni,
    .port       (macro_port)
  );

endmodule : otp_ctrl_top

//--- src/otp_dai.sv
// Wishbone classic slave of the direct access interface for single ordinary OTP words
`timescale 1ns/1ps

module otp_dai
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
#(
  parameter int LcOffset   = LcOffsetDefault,
  parameter int LcNumWords = LcNumWordsDefault
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Wishbone classic
  input  logic          wb_cyc_i,
  input  logic          wb_stb_i,
  input  logic          wb_we_i,
  input  otp_addr_t     wb_adr_i,
  input  otp_word_t     wb_dat_i,
  output otp_word_t     wb_dat_o,
  output logic          wb_ack_o,
  output logic          wb_err_o,
  otp_port_if.requester port
);

  typedef enum logic [1:0] {
    DaiIdle,
    DaiReq,
    DaiWait,
    DaiResp
  } dai_state_e;

  dai_state_e state_d, state_q;
  logic       stb_q;
  logic       start;
  logic       in_lc;
  logic       rsp;
  logic       we_q;
  otp_addr_t  addr_q;
  otp_word_t  wdata_q;

  // New cycle on the rising edge of cyc and stb
  assign start = wb_cyc_i && wb_stb_i && !stb_q;

  // Life cycle words are owned by the LCI
  assign in_lc = (int'(wb_adr_i) >= LcOffset) && (int'(wb_adr_i) < LcOffset + LcNumWords);

  always_comb begin
    state_d = state_q;
    case (state_q)
      DaiIdle: begin
        if (start) begin
          state_d = in_lc ? DaiResp : DaiReq;
        end
      end
      DaiReq: begin
        if (port.gnt) begin
          state_d = DaiWait;
        end
      end
      DaiWait: begin
        if (port.rvalid) begin
          state_d = DaiIdle;
        end
      end
      DaiResp: begin
        state_d = DaiIdle;
      end
      default: begin
        state_d = DaiIdle;
      end
    endcase
  end

  // Port request from latched payload
  assign port.req   = state_q == DaiReq;
  assign port.cmd   = we_q ? Write : Read;
  assign port.addr  = addr_q;
  assign port.wdata = wdata_q;

  // Bus response follows the macro response or one cycle after stb for the refused region
  assign rsp      = (state_q == DaiWait) && port.rvalid;
  assign wb_ack_o = rsp && (port.err == MacroOk);
  assign wb_err_o = (rsp && (port.err != MacroOk)) || (state_q == DaiResp);
  assign wb_dat_o = wb_ack_o ? port.rdata : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DaiIdle;
      stb_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      stb_q   <= wb_cyc_i && wb_stb_i;
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (state_q == DaiIdle && start) begin
      we_q    <= wb_we_i;
      addr_q  <= wb_adr_i;
      wdata_q <= wb_dat_i;
    end
  end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o));

endmodule : otp_dai

//--- src/otp_lci.sv
// Life cycle interface FSM that burns the life cycle partition word by word
`timescale 1ns/1ps

module otp_lci
  import otp_macro_pkg::*;
  import otp_ctrl_pkg::*;
#(
  parameter int LcOffset   = LcOffsetDefault,
  parameter int LcNumWords = LcNumWordsDefault
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       lci_en_i,
  // Escalation, forces the terminal state
  input  lc_tx_t                     escalate_en_i,
  // Transition request from the life cycle controller
  input  logic                       lc_req_i,
  input  otp_word_t [LcNumWords-1:0] lc_data_i,
  output logic                       lc_ack_o,
  output logic                       lc_err_o,
  // Status
  output otp_err_e                   error_o,
  output logic                       fsm_err_o,
  output logic                       lci_idle_o,
  otp_port_if.requester              port
);

  localparam int CntWidth = (LcNumWords > 1) ? $clog2(LcNumWords) : 1;
  localparam logic [CntWidth-1:0] LastCnt = CntWidth'(LcNumWords - 1);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  // Sparse encoding, minimum Hamming distance 5
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } lci_state_e;

  lci_state_e          state_d, state_q;
  otp_err_e            error_d, error_q;
  logic [CntWidth-1:0] cnt_q;
  logic                cnt_clr, cnt_en;
  logic                otp_req;
  otp_cmd_e            otp_cmd;

  assign error_o = error_q;

  always_comb begin
    state_d    = state_q;
    error_d    = error_q;
    cnt_clr    = 1'b0;
    cnt_en     = 1'b0;
    otp_req    = 1'b0;
    otp_cmd    = Read;
    lc_ack_o   = 1'b0;
    lc_err_o   = 1'b0;
    fsm_err_o  = 1'b0;
    lci_idle_o = 1'b0;

    unique case (state_q)
      // Wait for enable after reset
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        lci_idle_o = 1'b1;
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Hold the write until the arbiter grants
      WriteSt: begin
        otp_req = 1'b1;
        otp_cmd = Write;
        if (port.gnt) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response, keep going on errors
      WriteWaitSt: begin
        if (port.rvalid) begin
          if (port.err != MacroOk) begin
            error_d = MacroWriteBlankError;
          end
          if (cnt_q == LastCnt) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any failed word locks the partition
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal, keeps the first latched error code
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides every state
    if (lc_tx_test_true_loose(escalate_en_i)) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  //////////////////////////////////////////////////
  // Port drive and registers
  //////////////////////////////////////////////////

  assign port.req   = otp_req;
  assign port.cmd   = otp_cmd;
  assign port.addr  = otp_addr_t'(LcOffset) + otp_addr_t'(cnt_q);
  assign port.wdata = otp_req ? lc_data_i[cnt_q] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Word counter never steps past the last partition word
  a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_en |-> cnt_q < LastCnt);

  // Ack only closes a write that the port accepted one cycle before
  a_ack_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_o |-> state_q == WriteWaitSt && $past(port.req && port.gnt));

endmodule : otp_lci

//--- src/otp_port_arb.sv
// Fixed-priority arbiter merging the LCI and DAI ports onto the macro port
`timescale 1ns/1ps

module otp_port_arb (
  input  logic          clk_i,
  input  logic          rst_ni,
  otp_port_if.responder lci_port,
  otp_port_if.responder dai_port,
  otp_port_if.requester macro_port
);

  typedef enum logic {
    ArbIdle,
    ArbBusy
  } arb_state_e;

  arb_state_e state_d, state_q;
  logic       sel_dai;
  logic       owner_dai_q;
  logic       accept;

  // LCI wins a tie
  assign sel_dai = !lci_port.req;

  //////////////////////////////////////////////////
  // Request path, zero added cycles
  //////////////////////////////////////////////////

  assign macro_port.req   = (state_q == ArbIdle) && (lci_port.req || dai_port.req);
  assign macro_port.cmd   = sel_dai ? dai_port.cmd : lci_port.cmd;
  assign macro_port.addr  = sel_dai ? dai_port.addr : lci_port.addr;
  assign macro_port.wdata = sel_dai ? dai_port.wdata : lci_port.wdata;

  // Loser sees gnt low and holds
  assign lci_port.gnt = (state_q == ArbIdle) && !sel_dai && macro_port.gnt;
  assign dai_port.gnt = (state_q == ArbIdle) && sel_dai && macro_port.gnt;

  assign accept = macro_port.req && macro_port.gnt;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  // rvalid to the owner only, data shared
  assign lci_port.rvalid = (state_q == ArbBusy) && !owner_dai_q && macro_port.rvalid;
  assign dai_port.rvalid = (state_q == ArbBusy) && owner_dai_q && macro_port.rvalid;
  assign lci_port.rdata  = macro_port.rdata;
  assign dai_port.rdata  = macro_port.rdata;
  assign lci_port.err    = macro_port.err;
  assign dai_port.err    = macro_port.err;

  // Ownership held from acceptance until the response
  always_comb begin
    state_d = state_q;
    if (state_q == ArbIdle && accept) begin
      state_d = ArbBusy;
    end else if (state_q == ArbBusy && macro_port.rvalid) begin
      state_d = ArbIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ArbIdle;
      owner_dai_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        owner_dai_q <= sel_dai;
      end
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lci_port.gnt && dai_port.gnt));

endmodule : otp_port_arb

//--- src/otp_macro.sv
// Behavioral OTP array, bits can only be set, clearing writes are refused
`timescale 1ns/1ps

module otp_macro
  import otp_macro_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  otp_port_if.responder port
);

  otp_word_t      mem_q [OtpNumWords];
  otp_word_t      old_word;
  logic           accept;
  logic           blank_fail;
  logic           rvalid_q;
  otp_word_t      rdata_q;
  otp_macro_err_e err_q;

  // Always ready
  assign port.gnt = port.req;
  assign accept   = port.req && port.gnt;

  // Programmed bit that the new word would clear
  assign old_word   = mem_q[port.addr];
  assign blank_fail = |(old_word & ~port.wdata);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      for (int i = 0; i < OtpNumWords; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      rvalid_q <= accept;
      if (accept && port.cmd == Write && !blank_fail) begin
        mem_q[port.addr] <= old_word | port.wdata;
      end
    end
  end

  // Response payload, one cycle after acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= old_word;
      err_q   <= (port.cmd == Write && blank_fail) ? MacroWriteBlankErr : MacroOk;
    end
  end

  assign port.rvalid = rvalid_q;
  assign port.rdata  = rdata_q;
  assign port.err    = err_q;

  // Every response belongs to a request accepted the cycle before
  a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    port.rvalid |-> $past(port.req && port.gnt));

endmodule : otp_macro

//--- src/otp_port_if.sv
// OTP request/response port interface with requester and responder modports
`timescale 1ns/1ps

interface otp_port_if
  import otp_macro_pkg::*;
();

  // Request side
  logic           req;
  otp_cmd_e       cmd;
  otp_addr_t      addr;
  otp_word_t      wdata;

  // Response side
  logic           gnt;
  logic           rvalid;
  otp_word_t      rdata;
  otp_macro_err_e err;

  // Issues requests, holds payload until gnt
  modport requester (
    output req, cmd, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  // Accepts requests, one rvalid per accepted request
  modport responder (
    input  req, cmd, addr, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface : otp_port_if

//--- src/otp_ctrl_pkg.sv
// Controller types: life cycle escalation flag, controller error code, partition layout
package otp_ctrl_pkg;

  //////////////////////////////////////////////////
  // Life cycle multi-bit flag
  //////////////////////////////////////////////////

  typedef logic [3:0] lc_tx_t;

  // Two valid encodings, complementary bit patterns
  localparam lc_tx_t LcTxOn  = 4'b0101;
  localparam lc_tx_t LcTxOff = 4'b1010;

  // Loose true, anything but Off counts as asserted
  function automatic logic lc_tx_test_true_loose(lc_tx_t val);
    return val != LcTxOff;
  endfunction

  //////////////////////////////////////////////////
  // Controller error code
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    NoError              = 2'd0,
    MacroWriteBlankError = 2'd1,
    AccessError          = 2'd2,
    FsmStateError        = 2'd3
  } otp_err_e;

  // Life cycle partition sits at the top of the array
  localparam int LcOffsetDefault   = 12;
  localparam int LcNumWordsDefault = 4;

endpackage : otp_ctrl_pkg

//--- src/otp_macro_pkg.sv
// OTP macro port types: word, address, command and macro error code
package otp_macro_pkg;

  //////////////////////////////////////////////////
  // Array geometry
  //////////////////////////////////////////////////

  // Native word width and number of words in the array
  localparam int OtpWidth    = 16;
  localparam int OtpNumWords = 16;

  // One native OTP word
  typedef logic [OtpWidth-1:0] otp_word_t;

  // Word address, 16 words
  typedef logic [$clog2(OtpNumWords)-1:0] otp_addr_t;

  //////////////////////////////////////////////////
  // Port command and response
  //////////////////////////////////////////////////

  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  // Write blank check failure is the only error of the array
  typedef enum logic {
    MacroOk            = 1'b0,
    MacroWriteBlankErr = 1'b1
  } otp_macro_err_e;

endpackage : otp_macro_pkg
